// ==== src/ecpu_defines.svh ====
`ifndef ECPU_DEFINES_SVH
`define ECPU_DEFINES_SVH

// data path and instruction width
`define ECPU_DWIDTH 16

// address width shared by rom and ram
`define ECPU_AWIDTH 10

// memory depths in words
`define ECPU_ROM_DEPTH 1024
`define ECPU_RAM_DEPTH 1024

// interrupt handler entry in program memory
`define ECPU_INT_VECTOR 10'h3F0

// immediate field width of the instruction
`define ECPU_IMM_WIDTH 12

`endif

// ==== src/ecpu_pkg.sv ====
package ecpu_pkg;

`include "ecpu_defines.svh"

  // opcode field, upper nibble of each instruction word
  typedef enum logic [3:0] {
    NOP,
    LDIA,
    LDIB,
    ADD,
    SUB,
    AND,
    OR,
    XOR,
    NOT,
    LDA,
    STA,
    JMP,
    JZ,
    JC,
    RETI,
    HLT
  } ecpu_op_e;

  typedef struct packed {
    ecpu_op_e                    op;
    logic [`ECPU_IMM_WIDTH-1:0]  operand;
  } ecpu_instr_t;

  // word handed from fetch to execute
  typedef struct packed {
    logic                     valid;
    logic [`ECPU_AWIDTH-1:0]  pc;
    ecpu_instr_t              instr;
  } ecpu_fetch_t;

  typedef struct packed {
    logic                     enable;
    logic                     rd;
    logic                     wr;
    logic [`ECPU_AWIDTH-1:0]  address;
    logic [`ECPU_DWIDTH-1:0]  rw_mask;
    logic [`ECPU_DWIDTH-1:0]  data;
  } ecpu_mem_req_t;

  typedef struct packed {
    logic c;
    logic v;
    logic z;
  } ecpu_flags_t;

endpackage

// ==== src/ecpu_rom.sv ====
`timescale 1ns/100ps

`include "ecpu_defines.svh"

module ecpu_rom (
  input  logic                     clk,
  input  logic                     rst,
  input  logic [`ECPU_AWIDTH-1:0]  rd_addr,
  output logic [`ECPU_DWIDTH-1:0]  data_out,
  input  logic                     prog_we,
  input  logic [`ECPU_AWIDTH-1:0]  prog_addr,
  input  logic [`ECPU_DWIDTH-1:0]  prog_data
);

  logic [`ECPU_DWIDTH-1:0] mem [`ECPU_ROM_DEPTH];

  // program load is only accepted while the core sits in reset
  always_ff @(posedge clk) begin
    if (rst && prog_we) begin
      mem[prog_addr] <= prog_data;
    end
  end

  // one read per cycle, data valid the following cycle
  always_ff @(posedge clk) begin
    data_out <= mem[rd_addr];
  end

endmodule

// ==== src/ecpu_ram.sv ====
`timescale 1ns/100ps

`include "ecpu_defines.svh"

module ecpu_ram (
  input  logic                     clk,
  input  logic                     rst,
  input  ecpu_pkg::ecpu_mem_req_t  req,
  output logic [`ECPU_DWIDTH-1:0]  data_out
);

  logic [`ECPU_DWIDTH-1:0] mem [`ECPU_RAM_DEPTH];
  logic [`ECPU_DWIDTH-1:0] merged;

  // only bits with a one in the mask take the new data
  assign merged = (mem[req.address] & ~req.rw_mask) | (req.data & req.rw_mask);

  always_ff @(posedge clk) begin
    if (req.enable && req.wr) begin
      mem[req.address] <= merged;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      data_out <= '0;
    end else if (req.enable && req.rd) begin
      data_out <= mem[req.address];
    end
  end

endmodule

// ==== src/ecpu_alu.sv ====
`timescale 1ns/100ps

`include "ecpu_defines.svh"

module ecpu_alu (
  input  logic                     clk,
  input  logic                     rst,
  input  logic [`ECPU_DWIDTH-1:0]  a,
  input  logic [`ECPU_DWIDTH-1:0]  b,
  input  ecpu_pkg::ecpu_op_e       op,
  input  logic                     flag_en,
  output logic [`ECPU_DWIDTH-1:0]  y,
  output ecpu_pkg::ecpu_flags_t    flags
);

  localparam int MSB = `ECPU_DWIDTH - 1;

  logic [`ECPU_DWIDTH:0] sum;
  logic [`ECPU_DWIDTH:0] diff;
  logic                  carry;
  logic                  ovf;

  // extra top bit holds carry out or borrow
  assign sum  = {1'b0, a} + {1'b0, b};
  assign diff = {1'b0, a} - {1'b0, b};

  always_comb begin
    y     = a;
    carry = 1'b0;
    ovf   = 1'b0;
    case (op)
      ecpu_pkg::ADD: begin
        y     = sum[MSB:0];
        carry = sum[`ECPU_DWIDTH];
        ovf   = (a[MSB] == b[MSB]) && (sum[MSB] != a[MSB]);
      end
      ecpu_pkg::SUB: begin
        y     = diff[MSB:0];
        carry = diff[`ECPU_DWIDTH];
        ovf   = (a[MSB] != b[MSB]) && (diff[MSB] != a[MSB]);
      end
      ecpu_pkg::AND: y = a & b;
      ecpu_pkg::OR:  y = a | b;
      ecpu_pkg::XOR: y = a ^ b;
      ecpu_pkg::NOT: y = ~a;
      default:       y = a;
    endcase
  end

  // logic ops fall through with carry and overflow cleared
  always_ff @(posedge clk) begin
    if (rst) begin
      flags <= '0;
    end else if (flag_en) begin
      flags.c <= carry;
      flags.v <= ovf;
      flags.z <= (y == '0);
    end
  end

endmodule

// ==== src/ecpu_fetch.sv ====
`timescale 1ns/100ps

`include "ecpu_defines.svh"

module ecpu_fetch (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     stall,
  input  logic                     redirect,
  input  logic [`ECPU_AWIDTH-1:0]  redirect_pc,
  output logic [`ECPU_AWIDTH-1:0]  rom_addr,
  input  logic [`ECPU_DWIDTH-1:0]  rom_data,
  output ecpu_pkg::ecpu_fetch_t    fetch
);

  logic [`ECPU_AWIDTH-1:0] pc;
  logic [`ECPU_AWIDTH-1:0] issued_pc;
  logic                    issued_valid;
  logic                    fetch_valid;
  logic [`ECPU_AWIDTH-1:0] fetch_pc;
  logic [`ECPU_DWIDTH-1:0] fetch_instr;

  // on a stall the rom re-reads the issued address so its data stays paired
  assign rom_addr = stall ? issued_pc : pc;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc           <= '0;
      issued_valid <= 1'b0;
      fetch_valid  <= 1'b0;
    end else if (redirect) begin
      // both words in flight are dropped
      pc           <= redirect_pc;
      issued_valid <= 1'b0;
      fetch_valid  <= 1'b0;
    end else if (!stall) begin
      pc           <= pc + 1'b1;
      issued_valid <= 1'b1;
      fetch_valid  <= issued_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall) begin
      issued_pc   <= pc;
      fetch_pc    <= issued_pc;
      fetch_instr <= rom_data;
    end
  end

  assign fetch = '{
    valid: fetch_valid,
    pc:    fetch_pc,
    instr: ecpu_pkg::ecpu_instr_t'(fetch_instr)
  };

endmodule

// ==== src/ecpu_execute.sv ====
`timescale 1ns/100ps

`include "ecpu_defines.svh"

module ecpu_execute (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     int_ext,
  input  ecpu_pkg::ecpu_fetch_t    fetch,
  output logic                     stall,
  output logic                     redirect,
  output logic [`ECPU_AWIDTH-1:0]  redirect_pc,
  output logic [`ECPU_DWIDTH-1:0]  alu_a,
  output logic [`ECPU_DWIDTH-1:0]  alu_b,
  output ecpu_pkg::ecpu_op_e       alu_op,
  output logic                     flag_en,
  input  logic [`ECPU_DWIDTH-1:0]  alu_y,
  input  ecpu_pkg::ecpu_flags_t    flags,
  output ecpu_pkg::ecpu_mem_req_t  ram_req,
  input  logic [`ECPU_DWIDTH-1:0]  ram_data,
  output logic [`ECPU_DWIDTH-1:0]  a_acc,
  output logic [`ECPU_DWIDTH-1:0]  b_acc,
  output logic                     halted
);

  typedef enum logic [1:0] {
    RUN,
    LOAD_WAIT,
    HALT
  } state_e;

  state_e                  state;
  ecpu_pkg::ecpu_op_e      op;
  logic [`ECPU_AWIDTH-1:0] addr;
  logic [`ECPU_DWIDTH-1:0] imm;
  logic [`ECPU_AWIDTH-1:0] ret_pc;
  logic                    int_open;
  logic                    take_int;
  logic                    exec;

  assign op   = fetch.instr.op;
  assign addr = fetch.instr.operand[`ECPU_AWIDTH-1:0];
  assign imm  = {{(`ECPU_DWIDTH-`ECPU_IMM_WIDTH){1'b0}}, fetch.instr.operand};

  // an accepted interrupt replaces the valid word instead of executing it
  assign take_int = int_ext && int_open && (state == RUN) && fetch.valid;
  assign exec     = (state == RUN) && fetch.valid && !take_int;

  assign stall  = (state == LOAD_WAIT);
  assign halted = (state == HALT);

  assign alu_a   = a_acc;
  assign alu_b   = b_acc;
  assign alu_op  = op;
  assign flag_en = exec && (op inside {ecpu_pkg::ADD, ecpu_pkg::SUB, ecpu_pkg::AND,
                                       ecpu_pkg::OR, ecpu_pkg::XOR, ecpu_pkg::NOT});

  assign ram_req.enable  = exec && (op == ecpu_pkg::LDA || op == ecpu_pkg::STA);
  assign ram_req.rd      = exec && (op == ecpu_pkg::LDA);
  assign ram_req.wr      = exec && (op == ecpu_pkg::STA);
  assign ram_req.address = addr;
  assign ram_req.rw_mask = '1;
  assign ram_req.data    = a_acc;

  // branches test the flags left by earlier instructions
  always_comb begin
    redirect    = 1'b0;
    redirect_pc = addr;
    if (take_int) begin
      redirect    = 1'b1;
      redirect_pc = `ECPU_INT_VECTOR;
    end else if (exec) begin
      case (op)
        ecpu_pkg::JMP: redirect = 1'b1;
        ecpu_pkg::JZ:  redirect = flags.z;
        ecpu_pkg::JC:  redirect = flags.c;
        ecpu_pkg::RETI: begin
          redirect    = 1'b1;
          redirect_pc = ret_pc;
        end
        default: redirect = 1'b0;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= RUN;
      a_acc    <= '0;
      b_acc    <= '0;
      int_open <= 1'b1;
    end else begin
      case (state)
        RUN: begin
          if (take_int) begin
            int_open <= 1'b0;
          end else if (exec) begin
            case (op)
              ecpu_pkg::LDIA: a_acc <= imm;
              ecpu_pkg::LDIB: b_acc <= imm;
              ecpu_pkg::ADD, ecpu_pkg::SUB, ecpu_pkg::AND,
              ecpu_pkg::OR, ecpu_pkg::XOR, ecpu_pkg::NOT: a_acc <= alu_y;
              ecpu_pkg::LDA:  state <= LOAD_WAIT;
              ecpu_pkg::RETI: int_open <= 1'b1;
              ecpu_pkg::HLT:  state <= HALT;
              default: ;
            endcase
          end
        end
        // ram data arrives one cycle after the read
        LOAD_WAIT: begin
          a_acc <= ram_data;
          state <= RUN;
        end
        default: state <= HALT;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (take_int) begin
      ret_pc <= fetch.pc;
    end
  end

endmodule

// ==== src/ecpu_top.sv ====
`timescale 1ns/100ps

`include "ecpu_defines.svh"

module ecpu_top (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     int_ext,
  input  logic                     prog_we,
  input  logic [`ECPU_AWIDTH-1:0]  prog_addr,
  input  logic [`ECPU_DWIDTH-1:0]  prog_data,
  output logic [`ECPU_DWIDTH-1:0]  a_acc,
  output logic [`ECPU_DWIDTH-1:0]  b_acc,
  output logic                     halted
);

  ecpu_pkg::ecpu_fetch_t   fetch_word;
  ecpu_pkg::ecpu_mem_req_t ram_req;
  ecpu_pkg::ecpu_flags_t   flags;
  ecpu_pkg::ecpu_op_e      alu_op;
  logic                    stall;
  logic                    redirect;
  logic [`ECPU_AWIDTH-1:0] redirect_pc;
  logic [`ECPU_AWIDTH-1:0] rom_addr;
  logic [`ECPU_DWIDTH-1:0] rom_data;
  logic [`ECPU_DWIDTH-1:0] ram_data;
  logic [`ECPU_DWIDTH-1:0] alu_a;
  logic [`ECPU_DWIDTH-1:0] alu_b;
  logic [`ECPU_DWIDTH-1:0] alu_y;
  logic                    flag_en;

  ecpu_fetch i_fetch (
    .clk         (clk),
    .rst         (rst),
    .stall       (stall),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .rom_addr    (rom_addr),
    .rom_data    (rom_data),
    .fetch       (fetch_word)
  );

  ecpu_execute i_execute (
    .clk         (clk),
    .rst         (rst),
    .int_ext     (int_ext),
    .fetch       (fetch_word),
    .stall       (stall),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .alu_a       (alu_a),
    .alu_b       (alu_b),
    .alu_op      (alu_op),
    .flag_en     (flag_en),
    .alu_y       (alu_y),
    .flags       (flags),
    .ram_req     (ram_req),
    .ram_data    (ram_data),
    .a_acc       (a_acc),
    .b_acc       (b_acc),
    .halted      (halted)
  );

  ecpu_alu i_alu (
    .clk     (clk),
    .rst     (rst),
    .a       (alu_a),
    .b       (alu_b),
    .op      (alu_op),
    .flag_en (flag_en),
    .y       (alu_y),
    .flags   (flags)
  );

  ecpu_ram i_ram (
    .clk      (clk),
    .rst      (rst),
    .req      (ram_req),
    .data_out (ram_data)
  );

  // program memory, loaded from outside while in reset
  ecpu_rom i_rom (
    .clk       (clk),
    .rst       (rst),
    .rd_addr   (rom_addr),
    .data_out  (rom_data),
    .prog_we   (prog_we),
    .prog_addr (prog_addr),
    .prog_data (prog_data)
  );

endmodule

// ==== bench/ecpu_clk_gen.sv ====
`timescale 1ns/100ps

module ecpu_clk_gen (
  output logic clk,
  output logic rst
);

  // 4 ns period
  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin
    rst = 1'b1;
    repeat (2) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

// ==== bench/ecpu_props.sv ====
`timescale 1ns/100ps

`include "ecpu_defines.svh"

module ecpu_props (
  input logic                     clk,
  input logic                     rst,
  input logic                     halted,
  input logic                     stall,
  input logic                     ram_wr,
  input logic                     take_int,
  input logic [`ECPU_AWIDTH-1:0]  redirect_pc,
  input logic                     fetch_valid,
  input logic [`ECPU_AWIDTH-1:0]  fetch_pc
);

  halt_after_reset: assert property (@(posedge clk) $fell(rst) |-> !halted)
    else $error("halted is set in the first cycle after reset");

  // from the second reset cycle on every register has been cleared
  no_write_in_reset: assert property (@(posedge clk) (rst && $past(rst)) |-> !ram_wr)
    else $error("ram write while reset is active");

  single_stall: assert property (@(posedge clk) stall |=> !stall)
    else $error("stall held for two cycles in a row");

  // the first valid word after the two bubbles comes from the vector
  int_vector: assert property (@(posedge clk) disable iff (rst)
    take_int |-> (redirect_pc == `ECPU_INT_VECTOR)
                 ##3 (fetch_valid && fetch_pc == `ECPU_INT_VECTOR))
    else $error("interrupt entry does not redirect to the vector");

endmodule

// ==== bench/ecpu_tb.sv ====
`timescale 1ns/100ps

`include "ecpu_defines.svh"

module ecpu_tb;

  localparam logic [15:0] HANDLER_VAL = 16'h05A5;
  localparam int ROW_CYCLES = 200;
  localparam int WAIT_LIMIT = 150;

  typedef struct packed {
    logic [7:0][15:0] prog;
    logic             irq;
    logic [15:0]      exp_a;
    logic [15:0]      exp_b;
  } row_t;

  logic        clk;
  logic        gen_rst;
  logic        load_rst;
  logic        rst;
  logic        int_ext;
  logic        prog_we;
  logic [9:0]  prog_addr;
  logic [15:0] prog_data;
  logic [15:0] a_acc;
  logic [15:0] b_acc;
  logic        halted;

  row_t        rows[$];
  string       names[$];
  logic [15:0] pgm[$];
  logic [15:0] handler[$];
  int          seed = 86;
  int          error_count = 0;

  assign rst = gen_rst || load_rst;

  ecpu_clk_gen i_clk_gen (
    .clk (clk),
    .rst (gen_rst)
  );

  ecpu_top i_dut (
    .clk       (clk),
    .rst       (rst),
    .int_ext   (int_ext),
    .prog_we   (prog_we),
    .prog_addr (prog_addr),
    .prog_data (prog_data),
    .a_acc     (a_acc),
    .b_acc     (b_acc),
    .halted    (halted)
  );

  bind ecpu_execute ecpu_props i_props (
    .clk         (clk),
    .rst         (rst),
    .halted      (halted),
    .stall       (stall),
    .ram_wr      (ram_req.wr),
    .take_int    (take_int),
    .redirect_pc (redirect_pc),
    .fetch_valid (fetch.valid),
    .fetch_pc    (fetch.pc)
  );

  function automatic logic [15:0] word(ecpu_pkg::ecpu_op_e op, logic [11:0] operand);
    return {op, operand};
  endfunction

  function void emit(ecpu_pkg::ecpu_op_e op, logic [11:0] operand);
    pgm.push_back(word(op, operand));
  endfunction

  // unused program words are filled with HLT
  function void add_row(string name, logic irq, logic [15:0] exp_a, logic [15:0] exp_b);
    row_t r;
    r.irq   = irq;
    r.exp_a = exp_a;
    r.exp_b = exp_b;
    for (int i = 0; i < 8; i++) begin
      r.prog[i] = (i < pgm.size()) ? pgm[i] : word(ecpu_pkg::HLT, 12'h000);
    end
    rows.push_back(r);
    names.push_back(name);
    pgm.delete();
  endfunction

  function automatic logic [15:0] arith_expect(ecpu_pkg::ecpu_op_e op, logic [15:0] a,
                                               logic [15:0] b);
    case (op)
      ecpu_pkg::ADD: return a + b;
      ecpu_pkg::SUB: return a - b;
      ecpu_pkg::AND: return a & b;
      ecpu_pkg::OR:  return a | b;
      ecpu_pkg::XOR: return a ^ b;
      ecpu_pkg::NOT: return ~a;
      default:       return a;
    endcase
  endfunction

  function void build_random_rows();
    ecpu_pkg::ecpu_op_e ops [6];
    string              op_names [6];
    logic [11:0]        a_imm;
    logic [11:0]        b_imm;
    ops      = '{ecpu_pkg::ADD, ecpu_pkg::SUB, ecpu_pkg::AND,
                 ecpu_pkg::OR, ecpu_pkg::XOR, ecpu_pkg::NOT};
    op_names = '{"rand_add", "rand_sub", "rand_and", "rand_or", "rand_xor", "rand_not"};
    for (int rep = 0; rep < 2; rep++) begin
      for (int k = 0; k < 6; k++) begin
        a_imm = 12'($random(seed));
        b_imm = 12'($random(seed));
        emit(ecpu_pkg::LDIA, a_imm);
        emit(ecpu_pkg::LDIB, b_imm);
        emit(ops[k], 12'h000);
        emit(ecpu_pkg::HLT, 12'h000);
        add_row(op_names[k], 1'b0, arith_expect(ops[k], {4'h0, a_imm}, {4'h0, b_imm}),
                {4'h0, b_imm});
      end
    end
  endfunction

  task automatic build_branch_rows(logic [11:0] add_b, logic [11:0] sub_b,
                                   logic [15:0] add_a_exp, logic [15:0] sub_a_exp,
                                   string add_name, string sub_name);
    // 0xFFFE + b, the LDIA at 5 is skipped only on a carry
    emit(ecpu_pkg::LDIA, 12'h001);
    emit(ecpu_pkg::NOT, 12'h000);
    emit(ecpu_pkg::LDIB, add_b);
    emit(ecpu_pkg::ADD, 12'h000);
    emit(ecpu_pkg::JC, 12'h006);
    emit(ecpu_pkg::LDIA, 12'h777);
    emit(ecpu_pkg::HLT, 12'h000);
    add_row(add_name, 1'b0, add_a_exp, {4'h0, add_b});
    emit(ecpu_pkg::LDIA, 12'h155);
    emit(ecpu_pkg::LDIB, sub_b);
    emit(ecpu_pkg::SUB, 12'h000);
    emit(ecpu_pkg::JZ, 12'h005);
    emit(ecpu_pkg::LDIA, 12'h777);
    emit(ecpu_pkg::HLT, 12'h000);
    add_row(sub_name, 1'b0, sub_a_exp, {4'h0, sub_b});
  endtask

  task automatic build_memory_row(logic [11:0] load_addr, logic [15:0] exp_a, string name);
    emit(ecpu_pkg::LDIA, 12'h2AB);
    emit(ecpu_pkg::STA, 12'h012);
    emit(ecpu_pkg::LDIA, 12'h0CD);
    emit(ecpu_pkg::STA, 12'h013);
    // A holds neither stored value when the load starts
    emit(ecpu_pkg::LDIA, 12'h0EE);
    emit(ecpu_pkg::LDIB, 12'h044);
    emit(ecpu_pkg::LDA, load_addr);
    emit(ecpu_pkg::HLT, 12'h000);
    add_row(name, 1'b0, exp_a, 16'h0044);
  endtask

  task automatic build_fixed_rows();
    build_branch_rows(12'h003, 12'h155, 16'h0001, 16'h0000, "add_carry_jc", "sub_zero_jz");
    build_branch_rows(12'h001, 12'h154, 16'h0777, 16'h0777, "add_nc_jc", "sub_nz_jz");
    build_memory_row(12'h012, 16'h02AB, "mem_addr_12");
    build_memory_row(12'h013, 16'h00CD, "mem_addr_13");
    // both accumulators are final before the jump
    emit(ecpu_pkg::LDIA, 12'h321);
    emit(ecpu_pkg::LDIB, 12'h0AA);
    emit(ecpu_pkg::JMP, 12'h006);
    emit(ecpu_pkg::LDIA, 12'h111);
    emit(ecpu_pkg::LDIB, 12'h222);
    emit(ecpu_pkg::NOT, 12'h000);
    emit(ecpu_pkg::HLT, 12'h000);
    add_row("jmp_skip", 1'b0, 16'h0321, 16'h00AA);
    // zero flag keeps the JZ spinning until the handler clears it
    emit(ecpu_pkg::SUB, 12'h000);
    emit(ecpu_pkg::JZ, 12'h001);
    emit(ecpu_pkg::LDIB, 12'h123);
    emit(ecpu_pkg::HLT, 12'h000);
    add_row("interrupt", 1'b1, HANDLER_VAL, 16'h0123);
    emit(ecpu_pkg::HLT, 12'h000);
    emit(ecpu_pkg::LDIA, 12'h0FF);
    add_row("reset_halt", 1'b0, 16'h0000, 16'h0000);
  endtask

  task automatic run_watchdog(int limit);
    repeat (limit) @(posedge clk);
    $display("timeout: the test rows did not finish within %0d cycles", limit);
    $display("TEST FAIL");
    $finish;
  endtask

  task automatic run_row(int n);
    row_t r;
    int   cycles;
    r = rows[n];
    @(negedge clk);
    load_rst = 1'b1;
    int_ext  = 1'b0;
    for (int i = 0; i < 8; i++) begin
      prog_we   = 1'b1;
      prog_addr = 10'(i);
      prog_data = r.prog[i];
      @(negedge clk);
    end
    for (int i = 0; i < handler.size(); i++) begin
      prog_addr = `ECPU_INT_VECTOR + 10'(i);
      prog_data = handler[i];
      @(negedge clk);
    end
    prog_we  = 1'b0;
    load_rst = 1'b0;
    if (r.irq) begin
      repeat (10) @(negedge clk);
      int_ext = 1'b1;
      cycles  = 0;
      while (a_acc !== HANDLER_VAL && cycles < WAIT_LIMIT) begin
        @(negedge clk);
        cycles++;
      end
      // line drops before the handler reaches RETI
      int_ext = 1'b0;
      assert (a_acc === HANDLER_VAL) else begin
        $display("%s: the interrupt handler was never entered", names[n]);
        error_count++;
      end
    end
    cycles = 0;
    while (halted !== 1'b1 && cycles < WAIT_LIMIT) begin
      @(negedge clk);
      cycles++;
    end
    assert (halted === 1'b1) else begin
      $display("%s: the core never reached its halt", names[n]);
      error_count++;
    end
    assert (a_acc === r.exp_a) else begin
      $display("ERROR %s a_acc expected %h actual %h", names[n], r.exp_a, a_acc);
      error_count++;
    end
    assert (b_acc === r.exp_b) else begin
      $display("ERROR %s b_acc expected %h actual %h", names[n], r.exp_b, b_acc);
      error_count++;
    end
  endtask

  initial begin
    int_ext   = 1'b0;
    prog_we   = 1'b0;
    prog_addr = '0;
    prog_data = '0;
    load_rst  = 1'b1;
    // handler sets A, clears z with OR, leaves time to drop the line
    handler.push_back(word(ecpu_pkg::LDIA, HANDLER_VAL[11:0]));
    handler.push_back(word(ecpu_pkg::OR, 12'h000));
    repeat (4) handler.push_back(word(ecpu_pkg::NOP, 12'h000));
    handler.push_back(word(ecpu_pkg::RETI, 12'h000));
    build_random_rows();
    build_fixed_rows();
    fork
      run_watchdog(rows.size() * ROW_CYCLES);
    join_none
    for (int n = 0; n < rows.size(); n++) begin
      run_row(n);
    end
    $display("%0d rows run, %0d errors", rows.size(), error_count);
    if (error_count == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// ==== list.f ====
+incdir+src
src/ecpu_pkg.sv
src/ecpu_rom.sv
src/ecpu_ram.sv
src/ecpu_alu.sv
src/ecpu_fetch.sv
src/ecpu_execute.sv
src/ecpu_top.sv
bench/ecpu_clk_gen.sv
bench/ecpu_props.sv
bench/ecpu_tb.sv
